/* logic/wbbridge_pkg.sv */
// AXI4 write to Wishbone bridge shared definitions
// Widths, burst and response codes, and the response queue entry type

package wbbridge_pkg;

	//////////////////////////////
	// Widths
	localparam int AXI_ID_W      = 4;
	localparam int AXI_ADDR_W    = 16;
	localparam int AXI_DATA_W    = 32;
	localparam int STRB_W        = 4;   // One enable per byte lane
	localparam int ADDR_LSBS     = 2;
	localparam int WB_ADDR_W     = 14;  // Word address, byte offset removed
	localparam int LEN_W         = 8;
	localparam int RESP_DEPTH_LG = 2;   // Four queued responses

	//////////////////////////////
	// Types
	typedef logic [AXI_ID_W-1:0]   axi_id_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [WB_ADDR_W-1:0]  wb_addr_t;
	typedef logic [AXI_DATA_W-1:0] data_t;
	typedef logic [STRB_W-1:0]     strb_t;
	typedef logic [LEN_W-1:0]      len_t;     // Beats minus one
	typedef logic [1:0]            burst_t;
	typedef logic [1:0]            resp_t;

	// One B channel response
	typedef struct packed {
		axi_id_t id;
		resp_t   resp;
	} resp_entry_t;

	//////////////////////////////
	// Codes
	localparam burst_t BURST_FIXED = 2'b00;
	localparam burst_t BURST_INCR  = 2'b01;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;

endpackage

/* logic/burst_decode.sv */
// Burst decode
// Takes one AXI write address at a time and walks the Wishbone
// word address across the beats of the burst

`timescale 1ns/1ps

module burst_decode (
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	input  logic                   i_awvalid,
	input  wbbridge_pkg::axi_id_t  i_awid,
	input  wbbridge_pkg::axi_addr_t i_awaddr,
	input  wbbridge_pkg::len_t     i_awlen,
	input  wbbridge_pkg::burst_t   i_awburst,
	input  logic                   i_beat_taken,
	input  logic                   i_burst_done,
	input  logic                   i_resp_full,
	output logic                   o_awready,
	output logic                   o_busy,
	output wbbridge_pkg::wb_addr_t o_wb_addr,
	output wbbridge_pkg::axi_id_t  o_burst_id
);

	logic                   aw_accept;
	logic                   step_en;     // Address advances per beat
	wbbridge_pkg::len_t     beats_left;
	wbbridge_pkg::wb_addr_t start_word;

	// No new burst while one runs or the response queue is full
	assign o_awready  = !o_busy && !i_resp_full;
	assign aw_accept  = i_awvalid && o_awready;
	assign start_word = i_awaddr[wbbridge_pkg::AXI_ADDR_W-1:wbbridge_pkg::ADDR_LSBS];

	//////////////////////////////
	// Busy state
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_busy <= 1'b0;
		else if (aw_accept)
			o_busy <= 1'b1;
		else if (i_burst_done)
			o_busy <= 1'b0;
	end

	//////////////////////////////
	// Burst registers and address walk
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (aw_accept)
		begin
			o_burst_id <= i_awid;
			o_wb_addr  <= start_word;
			beats_left <= i_awlen;
			case (i_awburst)
				wbbridge_pkg::BURST_FIXED: step_en <= 1'b0;
				wbbridge_pkg::BURST_INCR:  step_en <= 1'b1;
				default:                   step_en <= 1'b1; // WRAP runs as INCR
			endcase
		end
		else if (i_beat_taken && (beats_left != '0))
		begin
			// Address holds on the final beat
			beats_left <= beats_left - 1'b1;
			if (step_en)
				o_wb_addr <= o_wb_addr + 1'b1;
		end
	end

endmodule

/* logic/wb_write_issue.sv */
// Wishbone write issue
// Accepts AXI write beats and turns each one into a pipelined
// Wishbone request, holding it while the slave stalls

`timescale 1ns/1ps

module wb_write_issue (
	input  logic                   S_AXI_ACLK,
	input  logic                   S_AXI_ARESETN,
	input  logic                   i_busy,
	input  logic                   i_err_state,
	input  logic                   i_burst_done,
	input  logic                   i_wvalid,
	input  logic                   i_wlast,
	input  wbbridge_pkg::data_t    i_wdata,
	input  wbbridge_pkg::strb_t    i_wstrb,
	input  wbbridge_pkg::wb_addr_t i_wb_addr,
	input  logic                   i_wb_stall,
	output logic                   o_wready,
	output logic                   o_beat_taken,
	output logic                   o_last_taken,
	output logic                   o_req_issued,
	output logic                   o_wb_cyc,
	output logic                   o_wb_stb,
	output wbbridge_pkg::wb_addr_t o_wb_adr,
	output wbbridge_pkg::data_t    o_wb_dat,
	output wbbridge_pkg::strb_t    o_wb_sel
);

	logic stb_free;    // Strobe slot can take a new request
	logic last_seen;   // WLAST taken, burst winding down
	logic issue_beat;

	assign stb_free = !o_wb_stb || !i_wb_stall;

	// In error the beats are still taken, then dropped
	assign o_wready     = i_busy && !last_seen && (i_err_state || stb_free);
	assign o_beat_taken = i_wvalid && o_wready;
	assign o_last_taken = o_beat_taken && i_wlast;
	assign issue_beat   = o_beat_taken && !i_err_state;
	assign o_req_issued = o_wb_stb && !i_wb_stall;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			last_seen <= 1'b0;
		else if (i_burst_done)
			last_seen <= 1'b0;
		else if (o_last_taken)
			last_seen <= 1'b1;
	end

	//////////////////////////////
	// Cycle and strobe
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else if (i_err_state)
		begin
			// Abort the bus cycle
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
		end
		else
		begin
			if (stb_free)
				o_wb_stb <= issue_beat;
			if (issue_beat)
				o_wb_cyc <= 1'b1;          // Opens with the first strobe
			else if (i_burst_done)
				o_wb_cyc <= 1'b0;
		end
	end

	// Request payload, only loaded when the strobe slot is free
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (issue_beat)
		begin
			o_wb_adr <= i_wb_addr;
			o_wb_dat <= i_wdata;
			o_wb_sel <= i_wstrb;   // Byte enables map straight to SEL
		end
	end

endmodule

/* logic/write_resp_track.sv */
// Write response tracking
// Counts Wishbone acknowledgements against issued requests, keeps a
// sticky error per burst and closes each burst with a response entry

`timescale 1ns/1ps

module write_resp_track (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_last_taken,
	input  logic                      i_req_issued,
	input  logic                      i_wb_ack,
	input  logic                      i_wb_err,
	input  logic                      i_wb_cyc,
	input  wbbridge_pkg::axi_id_t     i_burst_id,
	input  logic                      i_resp_full,
	output logic                      o_err_state,
	output logic                      o_burst_done,
	output logic                      o_push,
	output wbbridge_pkg::resp_entry_t o_entry
);

	logic [wbbridge_pkg::LEN_W:0] outstanding;  // Issued but not yet acked
	logic                         last_flag;
	logic                         last_issued;  // Final request has gone out
	logic                         err_flag;
	logic                         ack_seen;
	logic                         err_seen;

	// Responses outside a bus cycle are ignored
	assign ack_seen = i_wb_cyc && i_wb_ack;
	assign err_seen = i_wb_cyc && i_wb_err;

	assign o_err_state  = err_flag || err_seen;
	assign o_burst_done = last_flag && !i_resp_full
			&& (o_err_state || (last_issued && (outstanding == '0)));
	assign o_push       = o_burst_done;

	always_comb
	begin
		o_entry.id   = i_burst_id;
		o_entry.resp = o_err_state ? wbbridge_pkg::RESP_SLVERR : wbbridge_pkg::RESP_OKAY;
	end

	//////////////////////////////
	// Outstanding request count
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			outstanding <= '0;
		else if (o_err_state || o_burst_done)
			outstanding <= '0;            // Abandoned after an error
		else
		begin
			case ({i_req_issued, ack_seen})
				2'b10:   outstanding <= outstanding + 1'b1;
				2'b01:   outstanding <= outstanding - 1'b1;
				default: outstanding <= outstanding;
			endcase
		end
	end

	//////////////////////////////
	// Burst state flags
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN || o_burst_done)
		begin
			last_flag   <= 1'b0;
			last_issued <= 1'b0;
			err_flag    <= 1'b0;
		end
		else
		begin
			if (i_last_taken)
				last_flag <= 1'b1;
			// Earlier beats have all issued by the time WLAST is taken
			if (last_flag && i_req_issued)
				last_issued <= 1'b1;
			if (err_seen)
				err_flag <= 1'b1;
		end
	end

endmodule

/* logic/resp_fifo.sv */
// Response queue
// Four-entry circular buffer of write responses feeding the B channel

`timescale 1ns/1ps

module resp_fifo (
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	input  logic                      i_push,
	input  wbbridge_pkg::resp_entry_t i_entry,
	input  logic                      i_pop,
	output logic                      o_full,
	output logic                      o_empty,
	output wbbridge_pkg::resp_entry_t o_entry
);

	wbbridge_pkg::resp_entry_t mem [0:(1 << wbbridge_pkg::RESP_DEPTH_LG)-1];

	// Extra top bit tells full from empty
	logic [wbbridge_pkg::RESP_DEPTH_LG:0] wr_ptr;
	logic [wbbridge_pkg::RESP_DEPTH_LG:0] rd_ptr;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[wbbridge_pkg::RESP_DEPTH_LG] != rd_ptr[wbbridge_pkg::RESP_DEPTH_LG])
			&& (wr_ptr[wbbridge_pkg::RESP_DEPTH_LG-1:0] == rd_ptr[wbbridge_pkg::RESP_DEPTH_LG-1:0]);
	assign o_entry = mem[rd_ptr[wbbridge_pkg::RESP_DEPTH_LG-1:0]];   // Head entry

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_push && !o_full)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_pop && !o_empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_push && !o_full)
			mem[wr_ptr[wbbridge_pkg::RESP_DEPTH_LG-1:0]] <= i_entry;
	end

endmodule

/* logic/axi_wb_write_bridge.sv */
// AXI4 write channel to Wishbone pipelined write bridge
// Burst decode, Wishbone issue, response tracking and the B queue

`timescale 1ns/1ps

module axi_wb_write_bridge (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,
	// AW channel
	input  logic                    i_s_axi_awvalid,
	output logic                    o_s_axi_awready,
	input  wbbridge_pkg::axi_id_t   i_s_axi_awid,
	input  wbbridge_pkg::axi_addr_t i_s_axi_awaddr,
	input  wbbridge_pkg::len_t      i_s_axi_awlen,
	input  wbbridge_pkg::burst_t    i_s_axi_awburst,
	// W channel
	input  logic                    i_s_axi_wvalid,
	output logic                    o_s_axi_wready,
	input  wbbridge_pkg::data_t     i_s_axi_wdata,
	input  wbbridge_pkg::strb_t     i_s_axi_wstrb,
	input  logic                    i_s_axi_wlast,
	// B channel
	output logic                    o_s_axi_bvalid,
	input  logic                    i_s_axi_bready,
	output wbbridge_pkg::axi_id_t   o_s_axi_bid,
	output wbbridge_pkg::resp_t     o_s_axi_bresp,
	// Wishbone master
	output logic                    o_wb_cyc,
	output logic                    o_wb_stb,
	output wbbridge_pkg::wb_addr_t  o_wb_adr,
	output wbbridge_pkg::data_t     o_wb_dat,
	output wbbridge_pkg::strb_t     o_wb_sel,
	input  logic                    i_wb_stall,
	input  logic                    i_wb_ack,
	input  logic                    i_wb_err
);

	logic                      busy;
	logic                      err_state;
	logic                      burst_done;
	logic                      beat_taken;
	logic                      last_taken;
	logic                      req_issued;
	logic                      resp_push;
	logic                      resp_pop;
	logic                      resp_full;
	logic                      resp_empty;
	wbbridge_pkg::wb_addr_t    beat_addr;
	wbbridge_pkg::axi_id_t     burst_id;
	wbbridge_pkg::resp_entry_t push_entry;
	wbbridge_pkg::resp_entry_t head_entry;

	assign o_s_axi_bvalid = !resp_empty;
	assign resp_pop       = o_s_axi_bvalid && i_s_axi_bready;
	assign o_s_axi_bid    = head_entry.id;
	assign o_s_axi_bresp  = head_entry.resp;

	burst_decode u_decode (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awvalid     (i_s_axi_awvalid),
		.i_awid        (i_s_axi_awid),
		.i_awaddr      (i_s_axi_awaddr),
		.i_awlen       (i_s_axi_awlen),
		.i_awburst     (i_s_axi_awburst),
		.i_beat_taken  (beat_taken),
		.i_burst_done  (burst_done),
		.i_resp_full   (resp_full),
		.o_awready     (o_s_axi_awready),
		.o_busy        (busy),
		.o_wb_addr     (beat_addr),
		.o_burst_id    (burst_id)
	);

	wb_write_issue u_issue (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_busy        (busy),
		.i_err_state   (err_state),
		.i_burst_done  (burst_done),
		.i_wvalid      (i_s_axi_wvalid),
		.i_wlast       (i_s_axi_wlast),
		.i_wdata       (i_s_axi_wdata),
		.i_wstrb       (i_s_axi_wstrb),
		.i_wb_addr     (beat_addr),
		.i_wb_stall    (i_wb_stall),
		.o_wready      (o_s_axi_wready),
		.o_beat_taken  (beat_taken),
		.o_last_taken  (last_taken),
		.o_req_issued  (req_issued),
		.o_wb_cyc      (o_wb_cyc),
		.o_wb_stb      (o_wb_stb),
		.o_wb_adr      (o_wb_adr),
		.o_wb_dat      (o_wb_dat),
		.o_wb_sel      (o_wb_sel)
	);

	write_resp_track u_track (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_last_taken  (last_taken),
		.i_req_issued  (req_issued),
		.i_wb_ack      (i_wb_ack),
		.i_wb_err      (i_wb_err),
		.i_wb_cyc      (o_wb_cyc),
		.i_burst_id    (burst_id),
		.i_resp_full   (resp_full),
		.o_err_state   (err_state),
		.o_burst_done  (burst_done),
		.o_push        (resp_push),
		.o_entry       (push_entry)
	);

	resp_fifo u_resp_fifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_push        (resp_push),
		.i_entry       (push_entry),
		.i_pop         (resp_pop),
		.o_full        (resp_full),
		.o_empty       (resp_empty),
		.o_entry       (head_entry)
	);

endmodule

/* test/bridge_write_asserts.sv */
// Bridge protocol assertions
// Bound to the bridge top level for Wishbone and AXI handshake rules

`timescale 1ns/1ps

module bridge_write_asserts (
	input logic                   S_AXI_ACLK,
	input logic                   S_AXI_ARESETN,
	input logic                   o_wb_cyc,
	input logic                   o_wb_stb,
	input logic                   i_wb_stall,
	input wbbridge_pkg::wb_addr_t o_wb_adr,
	input wbbridge_pkg::data_t    o_wb_dat,
	input wbbridge_pkg::strb_t    o_wb_sel,
	input logic                   o_s_axi_bvalid,
	input logic                   i_s_axi_bready,
	input logic                   o_s_axi_awready
);

	a_stb_in_cyc: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
			o_wb_stb |-> o_wb_cyc) else $error("Strobe without cycle");

	// Request payload holds under stall
	a_stall_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
			(o_wb_stb && i_wb_stall) |=> ($stable(o_wb_adr) && $stable(o_wb_dat)
			&& $stable(o_wb_sel))) else $error("Request changed while stalled");

	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
			(o_s_axi_bvalid && !i_s_axi_bready) |=> o_s_axi_bvalid)
			else $error("BVALID dropped before BREADY");

	// An open bus cycle belongs to the running burst
	a_aw_busy: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
			o_wb_cyc |-> !o_s_axi_awready) else $error("AWREADY high during a burst");

endmodule

bind axi_wb_write_bridge bridge_write_asserts u_asserts (
	.S_AXI_ACLK      (S_AXI_ACLK),
	.S_AXI_ARESETN   (S_AXI_ARESETN),
	.o_wb_cyc        (o_wb_cyc),
	.o_wb_stb        (o_wb_stb),
	.i_wb_stall      (i_wb_stall),
	.o_wb_adr        (o_wb_adr),
	.o_wb_dat        (o_wb_dat),
	.o_wb_sel        (o_wb_sel),
	.o_s_axi_bvalid  (o_s_axi_bvalid),
	.i_s_axi_bready  (i_s_axi_bready),
	.o_s_axi_awready (o_s_axi_awready)
);

/* test/tb_axi_wb_write_bridge.sv */
// Testbench for the AXI4 write to Wishbone bridge
// Table of bursts driven by an AXI master, a stalling Wishbone slave
// model with ack and error injection, and typed checks

`timescale 1ns/1ps

module tb_axi_wb_write_bridge;

	typedef struct {
		wbbridge_pkg::axi_id_t   id;
		wbbridge_pkg::axi_addr_t addr;
		wbbridge_pkg::len_t      len;
		wbbridge_pkg::burst_t    burst;
		wbbridge_pkg::strb_t     strb;
		int                      err_beat;   // Request index that errs, -1 for none
		bit                      hold_b;     // BREADY low during this burst
	} row_t;

	localparam int NUM_ROWS = 11;
	localparam int LIMIT    = 300;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic i_s_axi_awvalid, o_s_axi_awready;
	wbbridge_pkg::axi_id_t   i_s_axi_awid;
	wbbridge_pkg::axi_addr_t i_s_axi_awaddr;
	wbbridge_pkg::len_t      i_s_axi_awlen;
	wbbridge_pkg::burst_t    i_s_axi_awburst;
	logic i_s_axi_wvalid, o_s_axi_wready, i_s_axi_wlast;
	wbbridge_pkg::data_t     i_s_axi_wdata;
	wbbridge_pkg::strb_t     i_s_axi_wstrb;
	logic o_s_axi_bvalid, i_s_axi_bready;
	wbbridge_pkg::axi_id_t   o_s_axi_bid;
	wbbridge_pkg::resp_t     o_s_axi_bresp;
	logic o_wb_cyc, o_wb_stb, i_wb_stall, i_wb_ack, i_wb_err;
	wbbridge_pkg::wb_addr_t  o_wb_adr;
	wbbridge_pkg::data_t     o_wb_dat;
	wbbridge_pkg::strb_t     o_wb_sel;

	row_t rows [0:NUM_ROWS-1];
	wbbridge_pkg::wb_addr_t log_adr[$];   // Requests seen by the slave
	wbbridge_pkg::data_t    log_dat[$];
	wbbridge_pkg::strb_t    log_sel[$];
	wbbridge_pkg::axi_id_t  exp_id_q[$];
	wbbridge_pkg::resp_t    exp_resp_q[$];
	int  due_q[$];
	bit  err_q[$];
	int  seed = 26;
	int  step_n, req_idx, err_beat_cur, errors, tests_ok, blocked_cnt;
	bit  err_pending;

	axi_wb_write_bridge dut (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	//////////////////////////////
	// Checks
	task automatic check_addr(input wbbridge_pkg::wb_addr_t got, exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_data(input wbbridge_pkg::data_t got, exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_sel(input wbbridge_pkg::strb_t got, exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_id(input wbbridge_pkg::axi_id_t got, exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_resp(input wbbridge_pkg::resp_t got, exp, input string name);
		if (got !== exp)
		begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timed out at %0t waiting for %s", $time, what);
		$display("Test failed");
		$finish;
	endtask

	task automatic wait_resp_drain();
		int n;
		n = 0;
		@(negedge S_AXI_ACLK);
		while (exp_id_q.size() != 0 && n < LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (n >= LIMIT)
			abort_on_timeout("outstanding write responses");
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	//////////////////////////////
	// Wishbone slave model
	always
	begin
		int d;
		@(negedge S_AXI_ACLK);
		if (!o_wb_cyc)
		begin
			due_q.delete();   // Aborted cycle drops pending acks
			err_q.delete();
		end
		if (S_AXI_ARESETN && o_wb_stb && !i_wb_stall)
		begin
			log_adr.push_back(o_wb_adr);
			log_dat.push_back(o_wb_dat);
			log_sel.push_back(o_wb_sel);
			d = step_n + 1 + (($random(seed) & 32'h7fff_ffff) % 3);
			if (due_q.size() != 0 && d <= due_q[$])
				d = due_q[$] + 1;     // Keep responses in request order
			due_q.push_back(d);
			err_q.push_back(req_idx == err_beat_cur);
			if (req_idx == err_beat_cur)
				err_pending = 1'b1;
			req_idx++;
		end
		@(posedge S_AXI_ACLK);
		#1;
		step_n++;
		i_wb_ack = 1'b0;
		i_wb_err = 1'b0;
		if (due_q.size() != 0 && due_q[0] == step_n)
		begin
			if (err_q[0])
			begin
				i_wb_err    = 1'b1;
				err_pending = 1'b0;
			end
			else
				i_wb_ack = 1'b1;
			void'(due_q.pop_front());
			void'(err_q.pop_front());
		end
		// Nothing more is accepted while an error is on its way
		i_wb_stall = i_wb_err || err_pending || (($random(seed) & 3) == 0);
	end

	// B channel monitor
	always
	begin
		@(negedge S_AXI_ACLK);
		if (S_AXI_ARESETN && o_s_axi_bvalid && i_s_axi_bready)
		begin
			if (exp_id_q.size() == 0)
			begin
				$display("Write response at %0t with no burst outstanding", $time);
				errors++;
			end
			else
			begin
				check_id(o_s_axi_bid, exp_id_q.pop_front(), "o_s_axi_bid");
				check_resp(o_s_axi_bresp, exp_resp_q.pop_front(), "o_s_axi_bresp");
			end
		end
	end

	//////////////////////////////
	// One burst from the table
	task automatic run_burst(input int r);
		row_t  t;
		int    n, b, exp_n, errs_before;
		bit    raise;
		wbbridge_pkg::wb_addr_t start;
		t           = rows[r];
		errs_before = errors;
		if (t.hold_b && !(r > 0 && rows[r-1].hold_b))
			wait_resp_drain();       // Start holding from an empty queue
		i_s_axi_bready = !t.hold_b;
		log_adr.delete();
		log_dat.delete();
		log_sel.delete();
		req_idx      = 0;
		err_beat_cur = t.err_beat;
		start        = wbbridge_pkg::wb_addr_t'(t.addr >> wbbridge_pkg::ADDR_LSBS);
		exp_n        = (t.err_beat < 0) ? (int'(t.len) + 1) : (t.err_beat + 1);

		i_s_axi_awvalid = 1'b1;
		i_s_axi_awid    = t.id;
		i_s_axi_awaddr  = t.addr;
		i_s_axi_awlen   = t.len;
		i_s_axi_awburst = t.burst;
		n = 0;
		@(negedge S_AXI_ACLK);
		while (!o_s_axi_awready && n < LIMIT)
		begin
			raise = 1'b0;
			if (!i_s_axi_bready && n == 6)
			begin
				$display("AW held off with %0d responses queued", exp_id_q.size());
				if (exp_id_q.size() != 4)
				begin
					$display("Response queue did not hold exactly four entries");
					errors++;
				end
				blocked_cnt++;
				raise = 1'b1;
			end
			@(posedge S_AXI_ACLK);
			#1;
			if (raise)
				i_s_axi_bready = 1'b1;
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (n >= LIMIT)
			abort_on_timeout("AWREADY");
		exp_id_q.push_back(t.id);
		exp_resp_q.push_back((t.err_beat < 0) ? wbbridge_pkg::RESP_OKAY
				: wbbridge_pkg::RESP_SLVERR);
		@(posedge S_AXI_ACLK);
		#1;
		i_s_axi_awvalid = 1'b0;

		for (b = 0; b <= int'(t.len); b++)
		begin
			i_s_axi_wvalid = 1'b1;
			i_s_axi_wdata  = 32'hC0DE_0000 | (r << 8) | b;
			i_s_axi_wstrb  = t.strb;
			i_s_axi_wlast  = (b == int'(t.len));
			n = 0;
			@(negedge S_AXI_ACLK);
			while (!o_s_axi_wready && n < LIMIT)
			begin
				@(negedge S_AXI_ACLK);
				n++;
			end
			if (n >= LIMIT)
				abort_on_timeout("WREADY");
			@(posedge S_AXI_ACLK);
			#1;
		end
		i_s_axi_wvalid = 1'b0;
		i_s_axi_wlast  = 1'b0;

		n = 0;
		@(negedge S_AXI_ACLK);
		while (o_wb_cyc && n < LIMIT)
		begin
			@(negedge S_AXI_ACLK);
			n++;
		end
		if (n >= LIMIT)
			abort_on_timeout("the Wishbone cycle to close");

		if (log_adr.size() != exp_n)
		begin
			$display("Burst %0d issued %0d Wishbone requests, expected %0d",
					r, log_adr.size(), exp_n);
			errors++;
		end
		for (b = 0; b < exp_n && b < log_adr.size(); b++)
		begin
			check_addr(log_adr[b], (t.burst == wbbridge_pkg::BURST_INCR)
					? wbbridge_pkg::wb_addr_t'(start + b) : start, "o_wb_adr");
			check_data(log_dat[b], 32'hC0DE_0000 | (r << 8) | b, "o_wb_dat");
			check_sel(log_sel[b], t.strb, "o_wb_sel");
		end
		if (errors == errs_before)
			tests_ok++;
		$display("Burst test %0d id %0h: %0d requests, %s", r, t.id, log_adr.size(),
				(errors == errs_before) ? "ok" : "mismatch");
		@(posedge S_AXI_ACLK);
		#1;
	endtask

	initial
	begin
		int r;
		S_AXI_ARESETN   = 1'b0;
		i_s_axi_awvalid = 1'b0;
		i_s_axi_awid    = '0;
		i_s_axi_awaddr  = '0;
		i_s_axi_awlen   = '0;
		i_s_axi_awburst = wbbridge_pkg::BURST_INCR;
		i_s_axi_wvalid  = 1'b0;
		i_s_axi_wdata   = '0;
		i_s_axi_wstrb   = '0;
		i_s_axi_wlast   = 1'b0;
		i_s_axi_bready  = 1'b1;
		i_wb_stall      = 1'b0;
		i_wb_ack        = 1'b0;
		i_wb_err        = 1'b0;
		err_beat_cur    = -1;

		// id, byte address, len, burst, strobe, error request, hold BREADY
		rows[0]  = '{4'h1, 16'h0100, 8'd3, wbbridge_pkg::BURST_INCR,  4'hF, -1, 1'b0};
		rows[1]  = '{4'h2, 16'h0204, 8'd3, wbbridge_pkg::BURST_FIXED, 4'h3, -1, 1'b0};
		rows[2]  = '{4'h3, 16'h0040, 8'd7, wbbridge_pkg::BURST_INCR,  4'hC,  2, 1'b0};
		rows[3]  = '{4'h4, 16'h0080, 8'd1, wbbridge_pkg::BURST_INCR,  4'hF, -1, 1'b0};
		rows[4]  = '{4'h5, 16'h1000, 8'd0, wbbridge_pkg::BURST_FIXED, 4'h5, -1, 1'b0};
		rows[5]  = '{4'h6, 16'h0300, 8'd1, wbbridge_pkg::BURST_INCR,  4'hF, -1, 1'b1};
		rows[6]  = '{4'h7, 16'h0310, 8'd1, wbbridge_pkg::BURST_INCR,  4'h1, -1, 1'b1};
		rows[7]  = '{4'h8, 16'h0320, 8'd2, wbbridge_pkg::BURST_INCR,  4'h2, -1, 1'b1};
		rows[8]  = '{4'h9, 16'h0330, 8'd1, wbbridge_pkg::BURST_FIXED, 4'h4, -1, 1'b1};
		rows[9]  = '{4'hA, 16'h0340, 8'd1, wbbridge_pkg::BURST_INCR,  4'h8, -1, 1'b1};
		rows[10] = '{4'hB, 16'h0400, 8'd2, wbbridge_pkg::BURST_FIXED, 4'hF,  0, 1'b0};

		repeat (2) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		@(posedge S_AXI_ACLK);
		#1;

		for (r = 0; r < NUM_ROWS; r++)
			run_burst(r);
		i_s_axi_bready = 1'b1;
		wait_resp_drain();
		if (blocked_cnt != 1)
		begin
			$display("AW was held off %0d times by a full response queue, expected once",
					blocked_cnt);
			errors++;
		end

		$display("Bursts passed %0d of %0d, errors %0d", tests_ok, NUM_ROWS, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* project.f */
logic/wbbridge_pkg.sv
logic/burst_decode.sv
logic/wb_write_issue.sv
logic/write_resp_track.sv
logic/resp_fifo.sv
logic/axi_wb_write_bridge.sv
test/bridge_write_asserts.sv
test/tb_axi_wb_write_bridge.sv

/* run_sim.sh */
#!/bin/bash
# Build the bridge testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_axi_wb_write_bridge -o sim_tb > build.log 2>&1 \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "No pass message in log"; exit 1; }
exit 0
